//--- verilog/buffer_ring_pkg.sv
`default_nettype none

package buffer_ring_pkg;

  // slot count, one router node and one RAM per slot
  localparam int SLOT_NUM = 4;

  // one wide datapath word
  localparam int DATA_W = 32;

  // 32 words per slot
  localparam int ADDR_W = 5;

  // request opcode
  // an all-zero request is idle, which is what a blocked path carries
  typedef enum logic [1:0] {
    REQ_IDLE  = 2'd0,
    REQ_READ  = 2'd1,
    REQ_WRITE = 2'd2
  } req_op_e;

  // mask register select on the config port
  typedef enum logic {
    CFG_WRITING = 1'b0,
    CFG_READING = 1'b1
  } cfg_sel_e;

endpackage

`default_nettype wire

//--- verilog/ring_route_cfg.sv
`default_nettype none

module ring_route_cfg (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  cfg_we,
  input  buffer_ring_pkg::cfg_sel_e             cfg_sel,
  input  logic [buffer_ring_pkg::SLOT_NUM-1:0]  cfg_mask,
  output logic [buffer_ring_pkg::SLOT_NUM-1:0]  ring_writing,
  output logic [buffer_ring_pkg::SLOT_NUM-1:0]  ring_reading
);

  import buffer_ring_pkg::*;

  // mask registers, new value steers the nodes one cycle later
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ring_writing <= '0;
      ring_reading <= '0;
    end else if (cfg_we) begin
      case (cfg_sel)
        CFG_WRITING: ring_writing <= cfg_mask;
        CFG_READING: ring_reading <= cfg_mask;
      endcase
    end
  end

  // a write with no valid select would silently drop a mode change
  assert property (@(posedge clk) disable iff (!rstn) cfg_we |-> !$isunknown(cfg_sel))
    else $error("cfg_sel unknown during a mask write");

endmodule

`default_nettype wire

//--- verilog/ring_router_node.sv
`default_nettype none

module ring_router_node (
  input  logic                                clk,
  input  logic                                rstn,
  // interconnect side
  input  buffer_ring_pkg::req_op_e            intc_op,
  input  logic [buffer_ring_pkg::ADDR_W-1:0]  intc_addr,
  input  logic [buffer_ring_pkg::DATA_W-1:0]  intc_wdata,
  output logic [buffer_ring_pkg::DATA_W-1:0]  intc_rdata,
  // own RAM side
  output buffer_ring_pkg::req_op_e            route_op,
  output logic [buffer_ring_pkg::ADDR_W-1:0]  route_addr,
  output logic [buffer_ring_pkg::DATA_W-1:0]  route_wdata,
  input  logic [buffer_ring_pkg::DATA_W-1:0]  route_rdata,
  // toward slot i-1
  input  buffer_ring_pkg::req_op_e            top_in_op,
  input  logic [buffer_ring_pkg::ADDR_W-1:0]  top_in_addr,
  input  logic [buffer_ring_pkg::DATA_W-1:0]  top_in_wdata,
  output buffer_ring_pkg::req_op_e            top_out_op,
  output logic [buffer_ring_pkg::ADDR_W-1:0]  top_out_addr,
  output logic [buffer_ring_pkg::DATA_W-1:0]  top_out_wdata,
  // toward slot i+1
  input  buffer_ring_pkg::req_op_e            bottom_in_op,
  input  logic [buffer_ring_pkg::ADDR_W-1:0]  bottom_in_addr,
  input  logic [buffer_ring_pkg::DATA_W-1:0]  bottom_in_wdata,
  output buffer_ring_pkg::req_op_e            bottom_out_op,
  output logic [buffer_ring_pkg::ADDR_W-1:0]  bottom_out_addr,
  output logic [buffer_ring_pkg::DATA_W-1:0]  bottom_out_wdata,
  // ring mode of this slot
  input  logic                                ring_writing,
  input  logic                                ring_reading
);

  import buffer_ring_pkg::*;

  // one register stage on every path
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      route_op         <= REQ_IDLE;
      route_addr       <= '0;
      route_wdata      <= '0;
      intc_rdata       <= '0;
      bottom_out_op    <= REQ_IDLE;
      bottom_out_addr  <= '0;
      bottom_out_wdata <= '0;
      top_out_op       <= REQ_IDLE;
      top_out_addr     <= '0;
      top_out_wdata    <= '0;
    end else begin
      // direct path and pass-through in both directions
      route_op         <= intc_op;
      route_addr       <= intc_addr;
      route_wdata      <= intc_wdata;
      intc_rdata       <= route_rdata;
      bottom_out_op    <= top_in_op;
      bottom_out_addr  <= top_in_addr;
      bottom_out_wdata <= top_in_wdata;
      top_out_op       <= bottom_in_op;
      top_out_addr     <= bottom_in_addr;
      top_out_wdata    <= bottom_in_wdata;

      // inject own request on the down chain, own RAM sees nothing
      if (ring_writing) begin
        bottom_out_op    <= intc_op;
        bottom_out_addr  <= intc_addr;
        bottom_out_wdata <= intc_wdata;
        route_op         <= REQ_IDLE;
        route_addr       <= '0;
        route_wdata      <= '0;
      end

      // take the upward request and drop it from the ring
      if (ring_reading) begin
        route_op      <= bottom_in_op;
        route_addr    <= bottom_in_addr;
        route_wdata   <= bottom_in_wdata;
        top_out_op    <= REQ_IDLE;
        top_out_addr  <= '0;
        top_out_wdata <= '0;
      end
    end
  end

  // neighbours and the interconnect must never feed X into the RAM
  assert property (@(posedge clk) disable iff (!rstn) !$isunknown(route_op))
    else $error("route_op unknown at a router node");

endmodule

`default_nettype wire

//--- verilog/ring_router.sv
`default_nettype none

module ring_router (
  input  logic                                  clk,
  input  logic                                  rstn,
  // interconnect ports
  input  buffer_ring_pkg::req_op_e              intc_op    [0:buffer_ring_pkg::SLOT_NUM-1],
  input  logic [buffer_ring_pkg::ADDR_W-1:0]    intc_addr  [0:buffer_ring_pkg::SLOT_NUM-1],
  input  logic [buffer_ring_pkg::DATA_W-1:0]    intc_wdata [0:buffer_ring_pkg::SLOT_NUM-1],
  output logic [buffer_ring_pkg::DATA_W-1:0]    intc_rdata [0:buffer_ring_pkg::SLOT_NUM-1],
  // RAM ports
  output buffer_ring_pkg::req_op_e              ram_op     [0:buffer_ring_pkg::SLOT_NUM-1],
  output logic [buffer_ring_pkg::ADDR_W-1:0]    ram_addr   [0:buffer_ring_pkg::SLOT_NUM-1],
  output logic [buffer_ring_pkg::DATA_W-1:0]    ram_wdata  [0:buffer_ring_pkg::SLOT_NUM-1],
  input  logic [buffer_ring_pkg::DATA_W-1:0]    ram_rdata  [0:buffer_ring_pkg::SLOT_NUM-1],
  input  logic [buffer_ring_pkg::SLOT_NUM-1:0]  ring_writing,
  input  logic [buffer_ring_pkg::SLOT_NUM-1:0]  ring_reading
);

  import buffer_ring_pkg::*;

  // down chain: bottom outputs of node i
  req_op_e             down_op    [0:SLOT_NUM-1];
  logic [ADDR_W-1:0]   down_addr  [0:SLOT_NUM-1];
  logic [DATA_W-1:0]   down_wdata [0:SLOT_NUM-1];
  // up chain: top outputs of node i
  req_op_e             up_op      [0:SLOT_NUM-1];
  logic [ADDR_W-1:0]   up_addr    [0:SLOT_NUM-1];
  logic [DATA_W-1:0]   up_wdata   [0:SLOT_NUM-1];

  for (genvar i = 0; i < SLOT_NUM; i++) begin : g_node
    req_op_e           top_in_op;
    logic [ADDR_W-1:0] top_in_addr;
    logic [DATA_W-1:0] top_in_wdata;
    req_op_e           bottom_in_op;
    logic [ADDR_W-1:0] bottom_in_addr;
    logic [DATA_W-1:0] bottom_in_wdata;

    // slot 0 turns the up chain back down
    if (i == 0) begin : g_top_fold
      assign top_in_op    = up_op[0];
      assign top_in_addr  = up_addr[0];
      assign top_in_wdata = up_wdata[0];
    end else begin : g_top_chain
      assign top_in_op    = down_op[i-1];
      assign top_in_addr  = down_addr[i-1];
      assign top_in_wdata = down_wdata[i-1];
    end

    // last slot turns the down chain back up
    if (i == SLOT_NUM - 1) begin : g_bottom_fold
      assign bottom_in_op    = down_op[i];
      assign bottom_in_addr  = down_addr[i];
      assign bottom_in_wdata = down_wdata[i];
    end else begin : g_bottom_chain
      assign bottom_in_op    = up_op[i+1];
      assign bottom_in_addr  = up_addr[i+1];
      assign bottom_in_wdata = up_wdata[i+1];
    end

    ring_router_node u_node (
      .clk              (clk),
      .rstn             (rstn),
      .intc_op          (intc_op[i]),
      .intc_addr        (intc_addr[i]),
      .intc_wdata       (intc_wdata[i]),
      .intc_rdata       (intc_rdata[i]),
      .route_op         (ram_op[i]),
      .route_addr       (ram_addr[i]),
      .route_wdata      (ram_wdata[i]),
      .route_rdata      (ram_rdata[i]),
      .top_in_op        (top_in_op),
      .top_in_addr      (top_in_addr),
      .top_in_wdata     (top_in_wdata),
      .top_out_op       (up_op[i]),
      .top_out_addr     (up_addr[i]),
      .top_out_wdata    (up_wdata[i]),
      .bottom_in_op     (bottom_in_op),
      .bottom_in_addr   (bottom_in_addr),
      .bottom_in_wdata  (bottom_in_wdata),
      .bottom_out_op    (down_op[i]),
      .bottom_out_addr  (down_addr[i]),
      .bottom_out_wdata (down_wdata[i]),
      .ring_writing     (ring_writing[i]),
      .ring_reading     (ring_reading[i])
    );

    // a writing slot keeps its own RAM quiet unless it also reads from the ring
    assert property (@(posedge clk) disable iff (!rstn)
      ring_writing[i] && !ring_reading[i] |=> ram_op[i] == REQ_IDLE)
      else $error("slot %0d reached its own RAM while in writing mode", i);
  end

endmodule

`default_nettype wire

//--- verilog/slot_ram.sv
`default_nettype none

module slot_ram (
  input  logic                                clk,
  input  logic                                rstn,
  input  buffer_ring_pkg::req_op_e            ram_op,
  input  logic [buffer_ring_pkg::ADDR_W-1:0]  ram_addr,
  input  logic [buffer_ring_pkg::DATA_W-1:0]  ram_wdata,
  output logic [buffer_ring_pkg::DATA_W-1:0]  ram_rdata
);

  import buffer_ring_pkg::*;

  // single-port storage, one slot
  logic [DATA_W-1:0] mem [0:(1 << ADDR_W)-1];

  always_ff @(posedge clk) begin
    if (ram_op == REQ_WRITE) begin
      mem[ram_addr] <= ram_wdata;
    end
  end

  // read port, value held until the next read
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      ram_rdata <= '0;
    end else if (ram_op == REQ_READ) begin
      ram_rdata <= mem[ram_addr];
    end
  end

endmodule

`default_nettype wire

//--- verilog/buffer_ring_top.sv
`default_nettype none

module buffer_ring_top (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  buffer_ring_pkg::req_op_e              intc_op    [0:buffer_ring_pkg::SLOT_NUM-1],
  input  logic [buffer_ring_pkg::ADDR_W-1:0]    intc_addr  [0:buffer_ring_pkg::SLOT_NUM-1],
  input  logic [buffer_ring_pkg::DATA_W-1:0]    intc_wdata [0:buffer_ring_pkg::SLOT_NUM-1],
  output logic [buffer_ring_pkg::DATA_W-1:0]    intc_rdata [0:buffer_ring_pkg::SLOT_NUM-1],
  input  logic                                  cfg_we,
  input  buffer_ring_pkg::cfg_sel_e             cfg_sel,
  input  logic [buffer_ring_pkg::SLOT_NUM-1:0]  cfg_mask
);

  import buffer_ring_pkg::*;

  logic [SLOT_NUM-1:0] ring_writing;
  logic [SLOT_NUM-1:0] ring_reading;

  // router to RAM, one set per slot
  req_op_e             ram_op    [0:SLOT_NUM-1];
  logic [ADDR_W-1:0]   ram_addr  [0:SLOT_NUM-1];
  logic [DATA_W-1:0]   ram_wdata [0:SLOT_NUM-1];
  logic [DATA_W-1:0]   ram_rdata [0:SLOT_NUM-1];

  ring_route_cfg u_cfg (
    .clk          (clk),
    .rstn         (rstn),
    .cfg_we       (cfg_we),
    .cfg_sel      (cfg_sel),
    .cfg_mask     (cfg_mask),
    .ring_writing (ring_writing),
    .ring_reading (ring_reading)
  );

  ring_router u_router (
    .clk          (clk),
    .rstn         (rstn),
    .intc_op      (intc_op),
    .intc_addr    (intc_addr),
    .intc_wdata   (intc_wdata),
    .intc_rdata   (intc_rdata),
    .ram_op       (ram_op),
    .ram_addr     (ram_addr),
    .ram_wdata    (ram_wdata),
    .ram_rdata    (ram_rdata),
    .ring_writing (ring_writing),
    .ring_reading (ring_reading)
  );

  for (genvar i = 0; i < SLOT_NUM; i++) begin : g_slot
    slot_ram u_ram (
      .clk       (clk),
      .rstn      (rstn),
      .ram_op    (ram_op[i]),
      .ram_addr  (ram_addr[i]),
      .ram_wdata (ram_wdata[i]),
      .ram_rdata (ram_rdata[i])
    );
  end

endmodule

`default_nettype wire

//--- tests/tb_buffer_ring.sv
`default_nettype none

module tb_buffer_ring;

  timeunit 1ns;
  timeprecision 100ps;

  import buffer_ring_pkg::*;

  localparam int WORDS = 1 << ADDR_W;
  localparam int ROUNDS = 24;
  // fill, direct, ring, dropped, mixed rounds and final readback, rounded up
  localparam int NUM_OPS = 2 * SLOT_NUM * WORDS + 4 * SLOT_NUM + 16 + ROUNDS * 8;
  localparam int TIMEOUT_CYCLES = NUM_OPS * (2 * SLOT_NUM + 6) + 200;

  logic                clk;
  logic                rstn;
  req_op_e             intc_op    [0:SLOT_NUM-1];
  logic [ADDR_W-1:0]   intc_addr  [0:SLOT_NUM-1];
  logic [DATA_W-1:0]   intc_wdata [0:SLOT_NUM-1];
  logic [DATA_W-1:0]   intc_rdata [0:SLOT_NUM-1];
  logic                cfg_we;
  cfg_sel_e            cfg_sel;
  logic [SLOT_NUM-1:0] cfg_mask;

  // expected contents of every slot
  logic [DATA_W-1:0] model [0:SLOT_NUM-1][0:WORDS-1];
  // word each port still shows from its previous read
  logic [DATA_W-1:0] last_rdata [0:SLOT_NUM-1];
  logic [31:0]       lcg_state;
  int                data_errs;
  int                op_errs;

  buffer_ring_top DUT (
    .clk        (clk),
    .rstn       (rstn),
    .intc_op    (intc_op),
    .intc_addr  (intc_addr),
    .intc_wdata (intc_wdata),
    .intc_rdata (intc_rdata),
    .cfg_we     (cfg_we),
    .cfg_sel    (cfg_sel),
    .cfg_mask   (cfg_mask)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // uniform-ish pick in 0..n-1 from the upper bits
  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[30:8]) % n;
  endfunction

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp) begin
      data_errs++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_op(input string name, input req_op_e exp, input req_op_e act);
    if (act !== exp) begin
      op_errs++;
      $display("ERR %s expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic drive_req(input int slot, input req_op_e op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
    intc_op[slot]    <= op;
    intc_addr[slot]  <= addr;
    intc_wdata[slot] <= data;
  endtask

  task automatic cfg_write(input cfg_sel_e sel, input logic [SLOT_NUM-1:0] mask);
    @(posedge clk);
    cfg_we   <= 1'b1;
    cfg_sel  <= sel;
    cfg_mask <= mask;
    @(posedge clk);
    cfg_we   <= 1'b0;
  endtask

  task automatic direct_write(input int slot, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data);
    @(posedge clk);
    drive_req(slot, REQ_WRITE, addr, data);
    @(posedge clk);
    drive_req(slot, REQ_IDLE, '0, '0);
  endtask

  // rdata shows up three cycles after the request cycle, not earlier
  task automatic direct_read_check(input string name, input int slot,
                                   input logic [ADDR_W-1:0] addr);
    @(posedge clk);
    drive_req(slot, REQ_READ, addr, '0);
    @(posedge clk);
    drive_req(slot, REQ_IDLE, '0, '0);
    @(posedge clk);
    @(negedge clk);
    check_data({name, "_early"}, last_rdata[slot], intc_rdata[slot]);
    @(posedge clk);
    @(negedge clk);
    check_data(name, model[slot][addr], intc_rdata[slot]);
    last_rdata[slot] = model[slot][addr];
  endtask

  // write injected at s, taken by reading slot d; drop >= 0 also hits a reading port
  task automatic ring_write(input int s, input int d, input int drop,
                            input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge clk);
    drive_req(s, REQ_WRITE, addr, data);
    if (drop >= 0) drive_req(drop, REQ_WRITE, ~addr, ~data);
    @(posedge clk);
    drive_req(s, REQ_IDLE, '0, '0);
    if (drop >= 0) drive_req(drop, REQ_IDLE, '0, '0);
    @(negedge clk);
    check_op("writer_quiet", REQ_IDLE, DUT.ram_op[s]);
    // down to the last slot, fold, then up to d
    repeat (2 * SLOT_NUM - s - d - 1) @(posedge clk);
    @(negedge clk);
    check_op("ring_arrival", REQ_WRITE, DUT.ram_op[d]);
    check_data("ring_wdata", data, DUT.ram_wdata[d]);
    repeat (s + d + 3) @(posedge clk);
    model[d][addr] = data;
  endtask

  initial begin
    logic [SLOT_NUM-1:0] wmask;
    logic [SLOT_NUM-1:0] rmask;
    logic [DATA_W-1:0]   w;
    int                  s;
    int                  d;
    int                  r;
    int                  a;
    lcg_state = 32'd59;
    data_errs = 0;
    op_errs   = 0;
    rstn      = 1'b0;
    cfg_we    = 1'b0;
    cfg_sel   = CFG_WRITING;
    cfg_mask  = '0;
    for (int i = 0; i < SLOT_NUM; i++) begin
      intc_op[i]    = REQ_IDLE;
      intc_addr[i]  = '0;
      intc_wdata[i] = '0;
      last_rdata[i] = '0;
    end
    repeat (2) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);

    for (int i = 0; i < SLOT_NUM; i++) begin
      check_data("reset_rdata", '0, intc_rdata[i]);
      check_op("reset_ram_op", REQ_IDLE, DUT.ram_op[i]);
    end

    // RAM contents are unknown after reset, so load every word first
    for (int i = 0; i < SLOT_NUM; i++) begin
      for (int j = 0; j < WORDS; j++) begin
        w = next_rand();
        direct_write(i, j[ADDR_W-1:0], w);
        model[i][j] = w;
      end
    end

    for (int i = 0; i < SLOT_NUM; i++) begin
      a = rand_below(WORDS);
      w = next_rand();
      direct_write(i, a[ADDR_W-1:0], w);
      model[i][a] = w;
      direct_read_check("direct_rw", i, a[ADDR_W-1:0]);
    end

    s = rand_below(SLOT_NUM);
    d = (s + 1 + rand_below(SLOT_NUM - 1)) % SLOT_NUM;
    wmask = '0;
    wmask[s] = 1'b1;
    rmask = '0;
    rmask[d] = 1'b1;
    cfg_write(CFG_WRITING, wmask);
    cfg_write(CFG_READING, rmask);
    a = rand_below(WORDS);
    ring_write(s, d, -1, a[ADDR_W-1:0], next_rand());
    cfg_write(CFG_WRITING, '0);
    cfg_write(CFG_READING, '0);
    direct_read_check("ring_dest", d, a[ADDR_W-1:0]);
    direct_read_check("ring_source", s, a[ADDR_W-1:0]);

    // a reading slot ignores its own port
    d = rand_below(SLOT_NUM);
    rmask = '0;
    rmask[d] = 1'b1;
    cfg_write(CFG_READING, rmask);
    a = rand_below(WORDS);
    direct_write(d, a[ADDR_W-1:0], next_rand());
    cfg_write(CFG_READING, '0);
    direct_read_check("dropped_write", d, a[ADDR_W-1:0]);

    repeat (ROUNDS) begin
      s = rand_below(SLOT_NUM);
      wmask = '0;
      wmask[s] = 1'b1;
      rmask = SLOT_NUM'(rand_below(1 << SLOT_NUM));
      rmask[s] = 1'b0;
      if (rmask == '0) rmask[(s + 1) % SLOT_NUM] = 1'b1;
      // highest reading slot meets the request first on the way up
      r = -1;
      for (int i = 0; i < SLOT_NUM; i++) begin
        if (rmask[i]) d = i;
        if (rmask[i] && r < 0) r = i;
      end
      if (rand_below(2) == 0) r = -1;
      cfg_write(CFG_WRITING, wmask);
      cfg_write(CFG_READING, rmask);
      a = rand_below(WORDS);
      ring_write(s, d, r, a[ADDR_W-1:0], next_rand());
      cfg_write(CFG_WRITING, '0);
      cfg_write(CFG_READING, '0);
      s = rand_below(SLOT_NUM);
      a = rand_below(WORDS);
      w = next_rand();
      direct_write(s, a[ADDR_W-1:0], w);
      model[s][a] = w;
      direct_read_check("mixed_direct", rand_below(SLOT_NUM), ADDR_W'(rand_below(WORDS)));
    end

    for (int i = 0; i < SLOT_NUM; i++) begin
      for (int j = 0; j < WORDS; j++) begin
        direct_read_check("final_readback", i, j[ADDR_W-1:0]);
      end
    end

    $display("errors: data %0d, op %0d", data_errs, op_errs);
    if (data_errs + op_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
verilog/buffer_ring_pkg.sv
verilog/ring_route_cfg.sv
verilog/ring_router_node.sv
verilog/ring_router.sv
verilog/slot_ram.sv
verilog/buffer_ring_top.sv
tests/tb_buffer_ring.sv

//--- run_sim.sh
#!/bin/sh
# build and run the buffer ring testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module tb_buffer_ring \
  -f flist.f

status=0
./obj_dir/Vtb_buffer_ring > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
  echo "result: FAIL"
  exit 1
fi

echo "result: PASS"
exit 0
